//--- include/sdram_defines.svh
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// ---------------------------------------------------------------------
// port address layout: row 25..12, bank 11..9, column 8..0
// ---------------------------------------------------------------------
`define SDRAM_ADDR_W 26
`define SDRAM_ROW_W 14
`define SDRAM_BANK_W 3
`define SDRAM_COL_W 9
`define SDRAM_WE_W 4

// ---------------------------------------------------------------------
// idle cycles required after each command
// ---------------------------------------------------------------------
`define SDRAM_TMR_W 4
`define SDRAM_GAP_ACTV 3
`define SDRAM_GAP_READ 4
`define SDRAM_GAP_WRTE 5
`define SDRAM_GAP_PRCH 4
`define SDRAM_GAP_ARSR 10

`define SDRAM_PRCH_ALL 14'h0400 // A10 high, all banks

`endif

//--- hdl/sdram_pkg.sv
`default_nettype none

`include "sdram_defines.svh"

package sdram_pkg;

  typedef logic [`SDRAM_ADDR_W-1:0] port_addr_t;
  typedef logic [`SDRAM_ROW_W-1:0] row_t;
  typedef logic [`SDRAM_BANK_W-1:0] bank_t;
  typedef logic [`SDRAM_COL_W-1:0] col_t;
  typedef logic [`SDRAM_ROW_W+`SDRAM_BANK_W-1:0] page_t; // {row, bank}
  typedef logic [`SDRAM_ROW_W-1:0] dram_addr_t;
  typedef logic [`SDRAM_WE_W-1:0] we_mask_t;
  typedef logic [`SDRAM_TMR_W-1:0] gap_t;

  // codes are {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011, // row open
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010, // row close
    ARSR = 3'b001  // auto refresh
  } sdram_cmd_e;

endpackage

`default_nettype wire

//--- hdl/sdram_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_arbiter (
  input  wire logic                  INPUT_CLK,
  input  wire logic                  RST,
  input  wire sdram_pkg::port_addr_t rand_addr,
  input  wire logic                  rand_write,
  input  wire logic                  rand_req,
  input  wire sdram_pkg::we_mask_t   rand_we,
  input  wire sdram_pkg::port_addr_t bulk_addr,
  input  wire logic                  bulk_write,
  input  wire logic                  bulk_req,
  input  wire sdram_pkg::we_mask_t   bulk_we,
  output logic                       sel_valid,
  output logic                       sel_bulk,
  output logic                       sel_write,
  output sdram_pkg::port_addr_t      sel_addr,
  output sdram_pkg::we_mask_t        sel_we
);

  import sdram_pkg::*;

  logic       rand_req_q;
  logic       bulk_req_q;
  logic       rand_write_q;
  logic       bulk_write_q;
  port_addr_t rand_addr_q;
  port_addr_t bulk_addr_q;
  we_mask_t   rand_we_q;
  we_mask_t   bulk_we_q;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      rand_req_q <= 1'b0;
      bulk_req_q <= 1'b0;
    end
    else
    begin
      rand_req_q <= rand_req;
      bulk_req_q <= bulk_req;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_write_q <= rand_write;
    bulk_write_q <= bulk_write;
    rand_addr_q  <= rand_addr;
    bulk_addr_q  <= bulk_addr;
    rand_we_q    <= rand_we;
    bulk_we_q    <= bulk_we;
  end

  assign sel_valid = bulk_req_q | rand_req_q;
  assign sel_bulk  = bulk_req_q; // bulk always wins
  assign sel_write = bulk_req_q ? bulk_write_q : rand_write_q;
  assign sel_addr  = bulk_req_q ? bulk_addr_q : rand_addr_q;
  assign sel_we    = bulk_req_q ? bulk_we_q : rand_we_q;

endmodule

`default_nettype wire

//--- hdl/sdram_page_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_page_tracker (
  input  wire logic                  INPUT_CLK,
  input  wire logic                  RST,
  input  wire sdram_pkg::sdram_cmd_e issued_cmd,
  input  wire sdram_pkg::port_addr_t sel_addr,
  output logic                       page_open,
  output logic                       page_hit,
  output sdram_pkg::bank_t           open_bank
);

  import sdram_pkg::*;

  page_t page_q;
  page_t sel_page;

  assign sel_page = sel_addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W]; // row and bank

  // ---------------------------------------------------------------------
  // open page state
  // ---------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_open <= 1'b0;
    end
    else if (issued_cmd == ACTV)
    begin
      page_open <= 1'b1;
    end
    else if (issued_cmd == PRCH)
    begin
      page_open <= 1'b0; // precharge closes every bank
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issued_cmd == ACTV)
    begin
      page_q <= sel_page;
    end
  end

  assign page_hit  = page_open && (sel_page == page_q);
  assign open_bank = page_q[`SDRAM_BANK_W-1:0]; // low field of page

endmodule

`default_nettype wire

//--- hdl/sdram_cmd_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_cmd_timer (
  input  wire logic                  INPUT_CLK,
  input  wire logic                  RST,
  input  wire sdram_pkg::sdram_cmd_e issued_cmd,
  output logic                       timer_ready
);

  import sdram_pkg::*;

  gap_t count;
  gap_t load_gap;

  // gap per command kind
  always_comb
  begin
    case (issued_cmd)
      ACTV:    load_gap = gap_t'(`SDRAM_GAP_ACTV);
      READ:    load_gap = gap_t'(`SDRAM_GAP_READ);
      WRTE:    load_gap = gap_t'(`SDRAM_GAP_WRTE);
      PRCH:    load_gap = gap_t'(`SDRAM_GAP_PRCH);
      ARSR:    load_gap = gap_t'(`SDRAM_GAP_ARSR);
      default: load_gap = gap_t'(0);
    endcase
  end

  // loaded on the edge that puts the command on the bus, so the
  // count equals the number of NOOP cycles that follow it
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      count <= gap_t'(0);
    end
    else if (issued_cmd != NOOP)
    begin
      count <= load_gap;
    end
    else if (count != gap_t'(0))
    begin
      count <= count - gap_t'(1);
    end
  end

  assign timer_ready = (count == gap_t'(0));

endmodule

`default_nettype wire

//--- hdl/sdram_cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_cmd_sequencer (
  input  wire logic                  INPUT_CLK,
  input  wire logic                  RST,
  input  wire logic                  refresh_strobe,
  input  wire logic                  timer_ready,
  input  wire logic                  sel_valid,
  input  wire logic                  sel_bulk,
  input  wire logic                  sel_write,
  input  wire sdram_pkg::port_addr_t sel_addr,
  input  wire sdram_pkg::we_mask_t   sel_we,
  input  wire logic                  page_open,
  input  wire logic                  page_hit,
  input  wire sdram_pkg::bank_t      open_bank,
  output sdram_pkg::sdram_cmd_e      issued_cmd,
  output sdram_pkg::sdram_cmd_e      cmd,
  output sdram_pkg::dram_addr_t      dram_addr,
  output sdram_pkg::bank_t           bank,
  output sdram_pkg::we_mask_t        we_out,
  output logic                       grant_rand,
  output logic                       grant_bulk
);

  import sdram_pkg::*;

  logic       refresh_ack;
  logic       refresh_pending;
  logic       rw_issue;
  sdram_cmd_e next_cmd;
  row_t       sel_row;
  bank_t      sel_bank;
  col_t       sel_col;

  assign sel_row  = sel_addr[`SDRAM_ADDR_W-1 -: `SDRAM_ROW_W];
  assign sel_bank = sel_addr[`SDRAM_COL_W +: `SDRAM_BANK_W];
  assign sel_col  = sel_addr[`SDRAM_COL_W-1:0];

  assign refresh_pending = refresh_ack ^ refresh_strobe; // toggle seen

  // ---------------------------------------------------------------------
  // command choice
  // ---------------------------------------------------------------------
  always_comb
  begin
    next_cmd = NOOP;
    if (refresh_pending)
    begin
      next_cmd = page_open ? PRCH : ARSR; // close the page first
    end
    else if (sel_valid)
    begin
      if (page_hit)
        next_cmd = sel_write ? WRTE : READ;
      else if (page_open)
        next_cmd = PRCH; // wrong page open
      else
        next_cmd = ACTV;
    end
  end

  assign issued_cmd = timer_ready ? next_cmd : NOOP;
  assign rw_issue   = (issued_cmd == READ) || (issued_cmd == WRTE);

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      refresh_ack <= refresh_strobe;
    else if (issued_cmd == ARSR)
      refresh_ack <= refresh_strobe;
  end

  // ---------------------------------------------------------------------
  // issue registers
  // ---------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      cmd        <= NOOP;
      grant_rand <= 1'b0;
      grant_bulk <= 1'b0;
    end
    else
    begin
      cmd        <= issued_cmd;
      grant_rand <= rw_issue & ~sel_bulk;
      grant_bulk <= rw_issue & sel_bulk;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    case (issued_cmd)
      ACTV:
      begin
        dram_addr <= sel_row;
        bank      <= sel_bank;
      end
      READ, WRTE:
      begin
        dram_addr <= {{(`SDRAM_ROW_W-`SDRAM_COL_W-1){1'b0}}, sel_col, 1'b0};
        bank      <= open_bank;
        we_out    <= sel_we;
      end
      PRCH:    dram_addr <= `SDRAM_PRCH_ALL;
      default: ; // pins hold
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/sdram_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_ctrl (
  input  wire logic                  INPUT_CLK,
  input  wire logic                  RST,
  input  wire logic                  refresh_strobe,
  input  wire sdram_pkg::port_addr_t rand_addr,
  input  wire logic                  rand_write,
  input  wire logic                  rand_req,
  input  wire sdram_pkg::we_mask_t   rand_we,
  input  wire sdram_pkg::port_addr_t bulk_addr,
  input  wire logic                  bulk_write,
  input  wire logic                  bulk_req,
  input  wire sdram_pkg::we_mask_t   bulk_we,
  output logic                       grant_rand,
  output logic                       grant_bulk,
  output sdram_pkg::sdram_cmd_e      cmd,
  output sdram_pkg::dram_addr_t      dram_addr,
  output sdram_pkg::bank_t           bank,
  output sdram_pkg::we_mask_t        we_out
);

  import sdram_pkg::*;

  logic       sel_valid;
  logic       sel_bulk;
  logic       sel_write;
  port_addr_t sel_addr;
  we_mask_t   sel_we;
  logic       page_open;
  logic       page_hit;
  bank_t      open_bank;
  sdram_cmd_e issued_cmd;
  logic       timer_ready;

  sdram_port_arbiter u_arbiter (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .rand_addr  (rand_addr),
    .rand_write (rand_write),
    .rand_req   (rand_req),
    .rand_we    (rand_we),
    .bulk_addr  (bulk_addr),
    .bulk_write (bulk_write),
    .bulk_req   (bulk_req),
    .bulk_we    (bulk_we),
    .sel_valid  (sel_valid),
    .sel_bulk   (sel_bulk),
    .sel_write  (sel_write),
    .sel_addr   (sel_addr),
    .sel_we     (sel_we)
  );

  sdram_page_tracker u_tracker (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .issued_cmd (issued_cmd),
    .sel_addr   (sel_addr),
    .page_open  (page_open),
    .page_hit   (page_hit),
    .open_bank  (open_bank)
  );

  sdram_cmd_timer u_timer (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .issued_cmd  (issued_cmd),
    .timer_ready (timer_ready)
  );

  sdram_cmd_sequencer u_sequencer (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .timer_ready    (timer_ready),
    .sel_valid      (sel_valid),
    .sel_bulk       (sel_bulk),
    .sel_write      (sel_write),
    .sel_addr       (sel_addr),
    .sel_we         (sel_we),
    .page_open      (page_open),
    .page_hit       (page_hit),
    .open_bank      (open_bank),
    .issued_cmd     (issued_cmd),
    .cmd            (cmd),
    .dram_addr      (dram_addr),
    .bank           (bank),
    .we_out         (we_out),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk)
  );

endmodule

`default_nettype wire

//--- dv/sdram_cmd_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_ctrl_tb;

  import sdram_pkg::*;

  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 400;
  localparam int CMD_WAIT        = 60; // longest wait for one command

  logic       INPUT_CLK;
  logic       RST;
  logic       refresh_strobe;
  port_addr_t rand_addr;
  logic       rand_write;
  logic       rand_req;
  we_mask_t   rand_we;
  port_addr_t bulk_addr;
  logic       bulk_write;
  logic       bulk_req;
  we_mask_t   bulk_we;
  logic       grant_rand;
  logic       grant_bulk;
  sdram_cmd_e cmd;
  dram_addr_t dram_addr;
  bank_t      bank;
  we_mask_t   we_out;

  logic [2:0] seen_cmd[$];
  dram_addr_t seen_addr[$];
  bank_t      seen_bank[$];
  we_mask_t   seen_we[$];
  logic [1:0] seen_grant[$]; // {bulk, rand}

  logic        have_prev;
  logic [2:0]  prev_cmd;
  int          noop_run;
  port_addr_t  page_addr; // address of the page left open
  int unsigned seed;
  int unsigned seed_draw;

  sdram_cmd_ctrl dut_i (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_addr      (rand_addr),
    .rand_write     (rand_write),
    .rand_req       (rand_req),
    .rand_we        (rand_we),
    .bulk_addr      (bulk_addr),
    .bulk_write     (bulk_write),
    .bulk_req       (bulk_req),
    .bulk_we        (bulk_we),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk),
    .cmd            (cmd),
    .dram_addr      (dram_addr),
    .bank           (bank),
    .we_out         (we_out)
  );

  always #4 INPUT_CLK = ~INPUT_CLK;

  // ----------------------------------------------------------------------
  // reference model of the address map and gaps
  // ----------------------------------------------------------------------
  function automatic int gap_after(input logic [2:0] c);
    case (c)
      ACTV:    return 3;
      READ:    return 4;
      WRTE:    return 5;
      PRCH:    return 4;
      ARSR:    return 10;
      default: return 0;
    endcase
  endfunction

  function automatic dram_addr_t row_of(input port_addr_t a);
    return a[25:12];
  endfunction

  function automatic bank_t bank_of(input port_addr_t a);
    return a[11:9];
  endfunction

  function automatic dram_addr_t col_addr_of(input port_addr_t a);
    return {4'b0000, a[8:0], 1'b0}; // column times two
  endfunction

  task automatic end_with_failure();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end_with_failure();
  endtask

  // ----------------------------------------------------------------------
  // bus monitor with the gap rule
  // ----------------------------------------------------------------------
  always @(negedge INPUT_CLK)
  begin
    if (RST)
    begin
      have_prev = 1'b0;
      noop_run  = 0;
    end
    else if (cmd != NOOP)
    begin
      if (have_prev)
        assert (noop_run >= gap_after(prev_cmd))
          else report_error($sformatf("only %0d idle cycles after command %b",
                                      noop_run, prev_cmd));
      seen_cmd.push_back(cmd);
      seen_addr.push_back(dram_addr);
      seen_bank.push_back(bank);
      seen_we.push_back(we_out);
      seen_grant.push_back({grant_bulk, grant_rand});
      prev_cmd  = cmd;
      have_prev = 1'b1;
      noop_run  = 0;
    end
    else
    begin
      assert (!grant_rand && !grant_bulk)
        else report_error("grant pulse on a NOOP cycle");
      noop_run++;
    end
  end

  task automatic expect_cmd(input sdram_cmd_e exp_cmd, input dram_addr_t exp_addr,
                            input bank_t exp_bank, input logic [1:0] exp_grant,
                            input we_mask_t exp_we);
    int         waited;
    logic [2:0] got_cmd;
    dram_addr_t got_addr;
    bank_t      got_bank;
    we_mask_t   got_we;
    logic [1:0] got_grant;
    waited = 0;
    while (seen_cmd.size() == 0 && waited < CMD_WAIT)
    begin
      @(posedge INPUT_CLK);
      waited++;
    end
    if (seen_cmd.size() == 0)
    begin
      $display("ERROR: no command appeared on the bus within %0d cycles, expected %b",
               CMD_WAIT, exp_cmd);
      end_with_failure();
    end
    got_cmd   = seen_cmd.pop_front();
    got_addr  = seen_addr.pop_front();
    got_bank  = seen_bank.pop_front();
    got_we    = seen_we.pop_front();
    got_grant = seen_grant.pop_front();
    assert (got_cmd == exp_cmd)
      else report_error($sformatf("command %b, expected %b", got_cmd, exp_cmd));
    if (exp_cmd != ARSR)
      assert (got_addr == exp_addr)
        else report_error($sformatf("dram_addr %h, expected %h", got_addr, exp_addr));
    if (exp_cmd == ACTV || exp_cmd == READ || exp_cmd == WRTE)
      assert (got_bank == exp_bank)
        else report_error($sformatf("bank %0d, expected %0d", got_bank, exp_bank));
    assert (got_grant == exp_grant)
      else report_error($sformatf("grants {bulk,rand} %b, expected %b", got_grant, exp_grant));
    if (exp_cmd == READ || exp_cmd == WRTE)
      assert (got_we == exp_we)
        else report_error($sformatf("we_out %h, expected %h", got_we, exp_we));
  endtask

  task automatic bus_stays_idle(input int cycles);
    repeat (cycles) @(posedge INPUT_CLK);
    assert (seen_cmd.size() == 0)
      else report_error($sformatf("unexpected command %b on an idle bus", seen_cmd[0]));
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic reset_state_is_idle();
    repeat (20)
    begin
      @(negedge INPUT_CLK);
      assert (cmd == NOOP && !grant_rand && !grant_bulk)
        else report_error("bus not idle after reset");
    end
    bus_stays_idle(1);
  endtask

  task automatic closed_bank_read();
    port_addr_t a;
    we_mask_t   m;
    a = port_addr_t'($urandom);
    m = we_mask_t'($urandom);
    @(negedge INPUT_CLK);
    rand_addr  = a;
    rand_write = 1'b0;
    rand_we    = m;
    rand_req   = 1'b1;
    expect_cmd(ACTV, row_of(a), bank_of(a), 2'b00, '0);
    expect_cmd(READ, col_addr_of(a), bank_of(a), 2'b01, m);
    @(negedge INPUT_CLK);
    rand_req  = 1'b0;
    page_addr = a;
  endtask

  task automatic page_hit_bulk_write();
    port_addr_t a;
    we_mask_t   m;
    a      = page_addr;
    a[8:0] = col_t'($urandom); // same row and bank
    m      = we_mask_t'($urandom);
    @(negedge INPUT_CLK);
    bulk_addr  = a;
    bulk_write = 1'b1;
    bulk_we    = m;
    bulk_req   = 1'b1;
    expect_cmd(WRTE, col_addr_of(a), bank_of(a), 2'b10, m);
    @(negedge INPUT_CLK);
    bulk_req = 1'b0;
  endtask

  task automatic page_miss_write();
    port_addr_t a;
    row_t       r;
    we_mask_t   m;
    r        = page_addr[25:12] + 1 + ($urandom % 100); // never the open row
    a        = page_addr;
    a[25:12] = r;
    m        = we_mask_t'($urandom);
    @(negedge INPUT_CLK);
    rand_addr  = a;
    rand_write = 1'b1;
    rand_we    = m;
    rand_req   = 1'b1;
    expect_cmd(PRCH, 14'h0400, '0, 2'b00, '0);
    expect_cmd(ACTV, row_of(a), bank_of(a), 2'b00, '0);
    expect_cmd(WRTE, col_addr_of(a), bank_of(a), 2'b01, m);
    @(negedge INPUT_CLK);
    rand_req  = 1'b0;
    page_addr = a;
  endtask

  task automatic refresh_closes_page();
    we_mask_t m;
    m = we_mask_t'($urandom);
    bus_stays_idle(12);
    @(negedge INPUT_CLK);
    refresh_strobe = ~refresh_strobe;
    expect_cmd(PRCH, 14'h0400, '0, 2'b00, '0);
    expect_cmd(ARSR, '0, '0, 2'b00, '0);
    bus_stays_idle(40); // a second refresh would show here
    @(negedge INPUT_CLK);
    rand_addr  = page_addr;
    rand_write = 1'b0;
    rand_we    = m;
    rand_req   = 1'b1;
    expect_cmd(ACTV, row_of(page_addr), bank_of(page_addr), 2'b00, '0);
    expect_cmd(READ, col_addr_of(page_addr), bank_of(page_addr), 2'b01, m);
    @(negedge INPUT_CLK);
    rand_req = 1'b0;
  endtask

  task automatic bulk_beats_random();
    port_addr_t ar;
    port_addr_t ab;
    we_mask_t   m;
    we_mask_t   mr;
    ar      = page_addr;
    ab      = page_addr;
    ar[8:0] = col_t'($urandom);
    ab[8:0] = col_t'($urandom);
    m       = we_mask_t'($urandom);
    mr      = we_mask_t'($urandom);
    @(negedge INPUT_CLK);
    rand_addr  = ar;
    rand_write = 1'b0;
    rand_we    = mr;
    rand_req   = 1'b1;
    bulk_addr  = ab;
    bulk_write = 1'b1;
    bulk_we    = m;
    bulk_req   = 1'b1;
    expect_cmd(WRTE, col_addr_of(ab), bank_of(ab), 2'b10, m);
    @(negedge INPUT_CLK);
    bulk_req = 1'b0;
    expect_cmd(READ, col_addr_of(ar), bank_of(ar), 2'b01, mr);
    @(negedge INPUT_CLK);
    rand_req = 1'b0;
    bus_stays_idle(20);
  endtask

  // ----------------------------------------------------------------------
  // run control
  // ----------------------------------------------------------------------
  initial
  begin
    INPUT_CLK      = 1'b0;
    RST            = 1'b1;
    refresh_strobe = 1'b0;
    rand_addr      = '0;
    rand_write     = 1'b0;
    rand_req       = 1'b0;
    rand_we        = '0;
    bulk_addr      = '0;
    bulk_write     = 1'b0;
    bulk_req       = 1'b0;
    bulk_we        = '0;
    have_prev      = 1'b0;
    noop_run       = 0;
    seed           = 32'h210c_0bd6;
    seed_draw      = $urandom(seed);
    repeat (4) @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    RST = 1'b0;
    reset_state_is_idle();
    closed_bank_read();
    page_hit_bulk_write();
    page_miss_write();
    refresh_closes_page();
    bulk_beats_random();
    $display("TB PASSED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge INPUT_CLK);
    $display("ERROR: simulation timed out after %0d clock cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

endmodule

`default_nettype wire

//--- sdram_cmd_ctrl.f
+incdir+include
hdl/sdram_pkg.sv
hdl/sdram_port_arbiter.sv
hdl/sdram_page_tracker.sv
hdl/sdram_cmd_timer.sv
hdl/sdram_cmd_sequencer.sv
hdl/sdram_cmd_ctrl.sv
dv/sdram_cmd_ctrl_tb.sv
